// ==== rtl/decodeStage.sv ====
`include "mipsParams.svh"

module decodeStage (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        pipeHold_i,
    input  logic        flush_i,
    input  logic        validD_i,
    input  logic [31:0] pcD_i,
    input  logic [31:0] instrD_i,
    output logic [4:0]  raddrA_o,
    output logic [4:0]  raddrB_o,
    input  logic [31:0] rdataA_i,
    input  logic [31:0] rdataB_i,
    decodeExecIf.decode dx
);

    mipsPkg::instrWord_u iw;
    mipsPkg::ctrl_t      ctrl;
    logic [31:0]         immExt;
    logic [4:0]          destNum;
    logic                supported;

    assign iw       = instrD_i;
    assign raddrA_o = iw.rType.rs;
    assign raddrB_o = iw.rType.rt;
    assign destNum  = (iw.iType.opcode == `OP_RTYPE) ? iw.rType.rd : iw.iType.rt;

    always_comb begin
        case (iw.iType.opcode)
            `OP_ORI: immExt = {16'h0, iw.iType.imm};
            `OP_LUI: immExt = {iw.iType.imm, 16'h0};
            default: immExt = {{16{iw.iType.imm[15]}}, iw.iType.imm};
        endcase
    end

    always_comb begin
        ctrl       = '0;   // unknown words fall out as a nop
        ctrl.aluOp = mipsPkg::ALU_ADD;
        supported  = 1'b1;
        case (iw.iType.opcode)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                case (iw.rType.funct)
                    `FN_ADDU: ctrl.aluOp = mipsPkg::ALU_ADD;
                    `FN_SUBU: ctrl.aluOp = mipsPkg::ALU_SUB;
                    `FN_AND:  ctrl.aluOp = mipsPkg::ALU_AND;
                    `FN_OR:   ctrl.aluOp = mipsPkg::ALU_OR;
                    `FN_SLT:  ctrl.aluOp = mipsPkg::ALU_SLT;
                    default: begin
                        ctrl.regWrite = 1'b0;
                        supported     = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_ORI: begin
                ctrl.aluOp    = mipsPkg::ALU_OR;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_LUI: begin
                ctrl.aluOp    = mipsPkg::ALU_LUI;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `OP_LW: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            `OP_SW: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.aluOp    = mipsPkg::ALU_SUB;
                ctrl.isBranch = 1'b1;
            end
            default: supported = 1'b0;
        endcase
        if (destNum == 5'd0) begin
            ctrl.regWrite = 1'b0;   // writes to $0 are dropped here
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            dx.valid <= 1'b0;
        end else if (!pipeHold_i) begin
            dx.valid <= validD_i & ~flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeHold_i) begin
            dx.pc      <= pcD_i;
            dx.ctrl    <= ctrl;
            dx.rsNum   <= iw.rType.rs;
            dx.rtNum   <= iw.rType.rt;
            dx.rsVal   <= rdataA_i;
            dx.rtVal   <= rdataB_i;
            dx.destNum <= destNum;
            dx.imm     <= immExt;
        end
    end

    // all-zero word is the usual sll-based nop and is let through quietly
    assert property (@(posedge clk) disable iff (!rstN_i)
        validD_i && !flush_i && !pipeHold_i |-> supported || instrD_i == 32'h0)
        else $error("unsupported instruction %h at pc %h", instrD_i, pcD_i);

endmodule

// ==== rtl/executeStage.sv ====
module executeStage (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        pipeHold_i,
    input  logic        wbWrite_i,
    input  logic [4:0]  wbNum_i,
    input  logic [31:0] wbData_i,
    output logic        branchTaken_o,
    output logic [31:0] branchTarget_o,
    decodeExecIf.exec   dx,
    execResultIf.exec   er
);

    logic [31:0] rsFwd;
    logic [31:0] rtFwd;
    logic [31:0] srcB;
    logic [31:0] aluOut;

    // memory-stage result overrides the value read in decode
    assign rsFwd = (wbWrite_i && wbNum_i == dx.rsNum && dx.rsNum != 5'd0) ? wbData_i : dx.rsVal;
    assign rtFwd = (wbWrite_i && wbNum_i == dx.rtNum && dx.rtNum != 5'd0) ? wbData_i : dx.rtVal;
    assign srcB  = dx.ctrl.useImm ? dx.imm : rtFwd;

    always_comb begin
        case (dx.ctrl.aluOp)
            mipsPkg::ALU_ADD: aluOut = rsFwd + srcB;
            mipsPkg::ALU_SUB: aluOut = rsFwd - srcB;
            mipsPkg::ALU_AND: aluOut = rsFwd & srcB;
            mipsPkg::ALU_OR:  aluOut = rsFwd | srcB;
            mipsPkg::ALU_SLT: aluOut = {31'h0, $signed(rsFwd) < $signed(srcB)};
            mipsPkg::ALU_LUI: aluOut = srcB;
            default:          aluOut = rsFwd + srcB;
        endcase
    end

    // only fires in the cycle the branch actually moves on
    assign branchTaken_o  = dx.valid && dx.ctrl.isBranch && (rsFwd == rtFwd) && !pipeHold_i;
    assign branchTarget_o = dx.pc + 32'd4 + {dx.imm[29:0], 2'b00};

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            er.valid <= 1'b0;
        end else if (!pipeHold_i) begin
            er.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeHold_i) begin
            er.pc        <= dx.pc;
            er.ctrl      <= dx.ctrl;
            er.aluOut    <= aluOut;
            er.storeData <= rtFwd;   // sw data, forwarded too
            er.destNum   <= dx.destNum;
        end
    end

    // a taken branch leaves a bubble behind it in execute
    assert property (@(posedge clk) disable iff (!rstN_i) branchTaken_o |=> !dx.valid)
        else $error("instruction behind a taken branch was not flushed");

endmodule

// ==== rtl/fetchStage.sv ====
`include "mipsParams.svh"

module fetchStage (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic        instStall_i,
    input  logic        dataStall_i,
    input  logic        branchTaken_i,
    input  logic [31:0] branchTarget_i,
    input  logic [31:0] instr_i,
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    output logic        pipeHold_o,
    output logic        validD_o,
    output logic [31:0] pcD_o,
    output logic [31:0] instrD_o
);

    logic [31:0] pc;
    logic        fetchEn;   // low only in the first cycle out of reset

    assign pipeHold_o = instStall_i | dataStall_i;   // freezes every stage
    assign instAddr_o = pc;
    assign instEn_o   = fetchEn;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pc       <= `RESET_PC;
            fetchEn  <= 1'b0;
            validD_o <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
            if (!pipeHold_o) begin
                if (branchTaken_i) begin
                    pc       <= branchTarget_i;
                    validD_o <= 1'b0;       // kill the word fetched behind the branch
                end else begin
                    pc       <= fetchEn ? pc + 32'd4 : pc;
                    validD_o <= fetchEn;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pipeHold_o) begin
            pcD_o    <= pc;
            instrD_o <= instr_i;
        end
    end

endmodule

// ==== rtl/mipsCore.sv ====
module mipsCore (
    input  logic        clk,
    input  logic        rstN_i,
    // instruction bus
    output logic [31:0] instAddr_o,
    output logic        instEn_o,
    input  logic [31:0] instr_i,
    input  logic        instStall_i,
    // data bus
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    input  logic [31:0] memRdata_i,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    input  logic        dataStall_i,
    // debug write port
    output logic [31:0] debugWbPc_o,
    output logic [3:0]  debugWbRfWen_o,
    output logic [4:0]  debugWbRfWnum_o,
    output logic [31:0] debugWbRfWdata_o
);

    logic        pipeHold;
    logic        validD;
    logic [31:0] pcD;
    logic [31:0] instrD;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic        wbWrite;
    logic [4:0]  wbNum;
    logic [31:0] wbData;
    logic [4:0]  raddrA;
    logic [4:0]  raddrB;
    logic [31:0] rdataA;
    logic [31:0] rdataB;

    decodeExecIf dxIf ();
    execResultIf erIf (.clk(clk));

    fetchStage fetch0 (
        .clk(clk), .rstN_i(rstN_i),
        .instStall_i(instStall_i), .dataStall_i(dataStall_i),
        .branchTaken_i(branchTaken), .branchTarget_i(branchTarget),
        .instr_i(instr_i),
        .instAddr_o(instAddr_o), .instEn_o(instEn_o), .pipeHold_o(pipeHold),
        .validD_o(validD), .pcD_o(pcD), .instrD_o(instrD)
    );

    regFile regFile0 (
        .clk(clk), .rstN_i(rstN_i),
        .raddrA_i(raddrA), .raddrB_i(raddrB),
        .we_i(wbWrite), .waddr_i(wbNum), .wdata_i(wbData),
        .rdataA_o(rdataA), .rdataB_o(rdataB)
    );

    decodeStage decode0 (
        .clk(clk), .rstN_i(rstN_i),
        .pipeHold_i(pipeHold), .flush_i(branchTaken),
        .validD_i(validD), .pcD_i(pcD), .instrD_i(instrD),
        .raddrA_o(raddrA), .raddrB_o(raddrB),
        .rdataA_i(rdataA), .rdataB_i(rdataB),
        .dx(dxIf.decode)
    );

    executeStage execute0 (
        .clk(clk), .rstN_i(rstN_i), .pipeHold_i(pipeHold),
        .wbWrite_i(wbWrite), .wbNum_i(wbNum), .wbData_i(wbData),
        .branchTaken_o(branchTaken), .branchTarget_o(branchTarget),
        .dx(dxIf.exec), .er(erIf.exec)
    );

    resultStage result0 (
        .pipeHold_i(pipeHold), .memRdata_i(memRdata_i),
        .memEn_o(memEn_o), .memAddr_o(memAddr_o),
        .memWen_o(memWen_o), .memWdata_o(memWdata_o),
        .wbWrite_o(wbWrite), .wbNum_o(wbNum), .wbData_o(wbData),
        .debugWbPc_o(debugWbPc_o), .debugWbRfWen_o(debugWbRfWen_o),
        .debugWbRfWnum_o(debugWbRfWnum_o), .debugWbRfWdata_o(debugWbRfWdata_o),
        .er(erIf.result)
    );

endmodule

// ==== rtl/mipsParams.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'b000000
`define OP_ADDIU 6'b001001
`define OP_ORI   6'b001101
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100

// funct field of R-type, instr[5:0]
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010

`endif

// ==== rtl/mipsPkg.sv ====
package mipsPkg;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rType_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iType_t;

    // same 32 bits, read as R-type or I-type
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI   // pass operand b, already shifted in decode
    } aluOp_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic   useImm;
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   isBranch;
    } ctrl_t;

endpackage

// ==== rtl/pipeIf.sv ====
// decode -> execute pipeline register contents
interface decodeExecIf;
    logic           valid;
    logic [31:0]    pc;
    mipsPkg::ctrl_t ctrl;
    logic [4:0]     rsNum;
    logic [4:0]     rtNum;
    logic [31:0]    rsVal;
    logic [31:0]    rtVal;
    logic [4:0]     destNum;
    logic [31:0]    imm;      // already extended

    modport decode (output valid, pc, ctrl, rsNum, rtNum, rsVal, rtVal, destNum, imm);
    modport exec   (input  valid, pc, ctrl, rsNum, rtNum, rsVal, rtVal, destNum, imm);
endinterface

// execute -> memory pipeline register contents
interface execResultIf (input logic clk);
    logic           valid;
    logic [31:0]    pc;
    mipsPkg::ctrl_t ctrl;
    logic [31:0]    aluOut;
    logic [31:0]    storeData;
    logic [4:0]     destNum;

    modport exec   (output valid, pc, ctrl, aluOut, storeData, destNum);
    modport result (input clk, valid, pc, ctrl, aluOut, storeData, destNum);
endinterface

// ==== rtl/regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        rstN_i,
    input  logic [4:0]  raddrA_i,
    input  logic [4:0]  raddrB_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdataA_o,
    output logic [31:0] rdataB_o
);

    logic [31:0] regs [1:31];   // $0 has no storage

    // write-first, so a producer in the memory stage reaches decode directly
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end else if (we_i && addr == waddr_i) begin
            return wdata_i;
        end else begin
            return regs[addr];
        end
    endfunction

    always_comb begin
        rdataA_o = readPort(raddrA_i);
        rdataB_o = readPort(raddrB_i);
    end

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // decode drops regWrite for $0, so the result stage must never ask for it
    assert property (@(posedge clk) disable iff (!rstN_i) !(we_i && waddr_i == 5'd0))
        else $error("register file write to $0");

endmodule

// ==== rtl/resultStage.sv ====
module resultStage (
    input  logic        pipeHold_i,
    input  logic [31:0] memRdata_i,
    output logic        memEn_o,
    output logic [31:0] memAddr_o,
    output logic [3:0]  memWen_o,
    output logic [31:0] memWdata_o,
    output logic        wbWrite_o,
    output logic [4:0]  wbNum_o,
    output logic [31:0] wbData_o,
    output logic [31:0] debugWbPc_o,
    output logic [3:0]  debugWbRfWen_o,
    output logic [4:0]  debugWbRfWnum_o,
    output logic [31:0] debugWbRfWdata_o,
    execResultIf.result er
);

    // data memory port, word access only
    assign memEn_o    = er.valid & (er.ctrl.memRead | er.ctrl.memWrite);
    assign memAddr_o  = er.aluOut;
    assign memWen_o   = {4{er.valid & er.ctrl.memWrite}};
    assign memWdata_o = er.storeData;

    // load data arrives in this same cycle
    assign wbData_o  = er.ctrl.memRead ? memRdata_i : er.aluOut;
    assign wbNum_o   = er.destNum;
    assign wbWrite_o = er.valid & er.ctrl.regWrite & ~pipeHold_i;

    assign debugWbPc_o      = er.pc;
    assign debugWbRfWen_o   = {4{wbWrite_o}};
    assign debugWbRfWnum_o  = er.destNum;
    assign debugWbRfWdata_o = wbData_o;

    // base + offset from execute must land on a word
    assert property (@(posedge er.clk) memEn_o |-> memAddr_o[1:0] == 2'b00)
        else $error("misaligned data access at %h, pc %h", memAddr_o, er.pc);

endmodule

// ==== src.f ====
+incdir+rtl
+incdir+verif
rtl/mipsPkg.sv
rtl/pipeIf.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/mipsCore.sv
verif/coreTb.sv

// ==== verif/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

`include "mipsParams.svh"

// columns: instruction word, expected dest register, expected value, test tag
// dest 0 means the word must not show on the debug write port
task automatic loadProgram();
    addInstr(encodeI(`OP_ADDIU, 5'd1, 5'd0, 16'd5), 5'd1, 32'd5, "imm");
    addInstr(encodeI(`OP_ADDIU, 5'd2, 5'd0, 16'hFFFD), 5'd2, 32'hFFFF_FFFD, "imm");
    addInstr(encodeI(`OP_ORI, 5'd3, 5'd0, 16'h8001), 5'd3, 32'h0000_8001, "imm");
    addInstr(encodeI(`OP_LUI, 5'd4, 5'd0, 16'h1234), 5'd4, 32'h1234_0000, "imm");
    addInstr(encodeR(`FN_ADDU, 5'd5, 5'd1, 5'd2), 5'd5, 32'd2, "rtype");
    addInstr(encodeR(`FN_SUBU, 5'd6, 5'd1, 5'd2), 5'd6, 32'd8, "rtype");
    addInstr(encodeR(`FN_AND, 5'd7, 5'd2, 5'd3), 5'd7, 32'h0000_8001, "rtype");
    addInstr(encodeR(`FN_OR, 5'd8, 5'd3, 5'd4), 5'd8, 32'h1234_8001, "rtype");
    addInstr(encodeR(`FN_SLT, 5'd9, 5'd2, 5'd1), 5'd9, 32'd1, "rtype");
    addInstr(encodeR(`FN_SLT, 5'd10, 5'd1, 5'd2), 5'd10, 32'd0, "rtype");
    addInstr(encodeR(`FN_ADDU, 5'd0, 5'd1, 5'd1), 5'd0, 32'd0, "");    // $0 stays silent
    addInstr(encodeI(`OP_ADDIU, 5'd11, 5'd0, 16'd7), 5'd11, 32'd7, "fwd");
    addInstr(encodeR(`FN_ADDU, 5'd12, 5'd11, 5'd11), 5'd12, 32'd14, "fwd");
    addInstr(encodeR(`FN_SUBU, 5'd13, 5'd12, 5'd11), 5'd13, 32'd7, "fwd");
    addInstr(encodeR(`FN_OR, 5'd14, 5'd13, 5'd12), 5'd14, 32'd15, "fwd");
    addInstr(encodeI(`OP_ADDIU, 5'd15, 5'd0, 16'h0020), 5'd15, 32'h20, "mem");
    addInstr(encodeI(`OP_SW, 5'd14, 5'd15, 16'd4), 5'd0, 32'd0, "");   // word 9
    addInstr(encodeI(`OP_LW, 5'd16, 5'd15, 16'd4), 5'd16, 32'd15, "mem");
    addInstr(encodeR(`FN_ADDU, 5'd17, 5'd16, 5'd1), 5'd17, 32'd20, "mem");
    addInstr(encodeI(`OP_BEQ, 5'd5, 5'd1, 16'd2), 5'd0, 32'd0, "");    // 5 != 2, falls through
    addInstr(encodeI(`OP_ADDIU, 5'd18, 5'd0, 16'd1), 5'd18, 32'd1, "branch");
    addInstr(encodeI(`OP_BEQ, 5'd12, 5'd12, 16'd2), 5'd0, 32'd0, "");  // taken
    addInstr(encodeI(`OP_ADDIU, 5'd19, 5'd0, 16'h0111), 5'd0, 32'd0, "");
    addInstr(encodeI(`OP_ADDIU, 5'd20, 5'd0, 16'h0222), 5'd0, 32'd0, "");
    addInstr(encodeI(`OP_ADDIU, 5'd21, 5'd0, 16'h0333), 5'd21, 32'h333, "branch");
    addInstr(encodeI(`OP_BEQ, 5'd0, 5'd21, 16'd5), 5'd0, 32'd0, "");   // not taken
    addInstr(encodeR(`FN_ADDU, 5'd23, 5'd21, 5'd18), 5'd23, 32'h334, "branch");
    // data words after the run
    addMemCheck(9, 32'd15);
    addMemCheck(8, fillWord(8));
endtask

`endif

// ==== verif/coreTb.sv ====
`include "mipsParams.svh"

module coreTb;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 6;   // quiet cycles watched after the last writeback
    localparam int IMEM_WORDS   = 64;
    localparam int DMEM_WORDS   = 64;

    logic        clk;
    logic        rstN;
    logic [31:0] instAddr;
    logic        instEn;
    logic [31:0] instr;
    logic        instStall;
    logic        memEn;
    logic [31:0] memAddr;
    logic [31:0] memRdata;
    logic [3:0]  memWen;
    logic [31:0] memWdata;
    logic        dataStall;
    logic [31:0] wbPc;
    logic [3:0]  wbEn;
    logic [4:0]  wbNum;
    logic [31:0] wbData;

    logic [31:0] progMem [IMEM_WORDS];
    logic [31:0] dataMem [DMEM_WORDS];
    int          progLen = 0;
    logic [4:0]  expNum [$];
    logic [31:0] expVal [$];
    logic [31:0] expPc [$];
    string       expTag [$];
    int          memIdx [$];
    logic [31:0] memVal [$];

    int wbSeen      = 0;
    int curChecks   = 0;
    int curErrors   = 0;
    int totalErrors = 0;
    int testsRun    = 0;
    int testsFailed = 0;
    int cycleCount  = 0;
    int cycleLimit  = 0;
    int cyclesOut   = 0;   // clock edges seen since reset release

    mipsCore dut0 (
        .clk(clk), .rstN_i(rstN),
        .instAddr_o(instAddr), .instEn_o(instEn), .instr_i(instr), .instStall_i(instStall),
        .memEn_o(memEn), .memAddr_o(memAddr), .memRdata_i(memRdata),
        .memWen_o(memWen), .memWdata_o(memWdata), .dataStall_i(dataStall),
        .debugWbPc_o(wbPc), .debugWbRfWen_o(wbEn),
        .debugWbRfWnum_o(wbNum), .debugWbRfWdata_o(wbData)
    );

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // every word starts out holding its own byte address
    function automatic logic [31:0] fillWord(input int idx);
        return 32'hD0A0_0000 | (idx << 2);
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic void addInstr(input logic [31:0] word, input logic [4:0] num,
                                     input logic [31:0] val, input string tag);
        progMem[progLen] = word;
        if (num != 5'd0) begin
            expNum.push_back(num);
            expVal.push_back(val);
            expPc.push_back(`RESET_PC + progLen * 4);   // one word per table row
            expTag.push_back(tag);
        end
        progLen++;
    endfunction

    function automatic void addMemCheck(input int idx, input logic [31:0] val);
        memIdx.push_back(idx);
        memVal.push_back(val);
    endfunction

    `include "tbProgram.svh"

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // both memories answer in the same cycle
    always_comb begin
        if (instAddr[31:2] < IMEM_WORDS) begin
            instr = progMem[instAddr[7:2]];
        end else begin
            instr = 32'h0;   // past the program, all nops
        end
    end

    always_comb memRdata = dataMem[memAddr[7:2]];

    task automatic countError();
        curErrors++;
        totalErrors++;
    endtask

    task automatic reportTest(input string name);
        testsRun++;
        if (curErrors != 0) begin
            testsFailed++;
        end
        $display("test %s: %0d checks, %0d errors, %s", name, curChecks, curErrors,
                 (curErrors == 0) ? "pass" : "fail");
        curChecks = 0;
        curErrors = 0;
    endtask

    // fetch runs from the second cycle out of reset whenever nothing holds
    task automatic checkFetch();
        if (cyclesOut > 0 && !instStall && !dataStall) begin
            curChecks++;
            assert (instEn === 1'b1) else begin
                $display("ERR %0t: instruction fetch disabled at pc %h without a stall",
                         $time, instAddr);
                countError();
            end
        end
    endtask

    task automatic checkWriteback();
        if (wbSeen >= expNum.size()) begin
            curChecks++;   // flushed words and nops must stay off the port
            assert (wbEn == 4'h0) else begin
                $display("ERR %0t: extra write $%0d = %h from pc %h", $time, wbNum, wbData, wbPc);
                countError();
            end
        end else if (wbEn != 4'h0) begin
            curChecks++;
            assert (wbEn == 4'hF && !instStall && !dataStall) else begin
                $display("ERR %0t: write enable %h with stalls %b/%b", $time, wbEn,
                         instStall, dataStall);
                countError();
            end
            assert (wbNum === expNum[wbSeen] && wbData === expVal[wbSeen] &&
                    wbPc === expPc[wbSeen]) else begin
                $display("ERR %0t: write $%0d = %h from pc %h, expected $%0d = %h from pc %h",
                         $time, wbNum, wbData, wbPc, expNum[wbSeen], expVal[wbSeen],
                         expPc[wbSeen]);
                countError();
            end
            wbSeen++;
            if (wbSeen == expNum.size() || expTag[wbSeen] != expTag[wbSeen - 1]) begin
                reportTest(expTag[wbSeen - 1]);
            end
        end
    endtask

    task automatic commitStore();
        if (memEn) begin
            assert (memAddr[31:2] < DMEM_WORDS) else begin
                $display("ERR %0t: data access at %h lies outside the data memory", $time,
                         memAddr);
                countError();
            end
            if (memWen == 4'hF && !dataStall) begin
                dataMem[memAddr[7:2]] <= memWdata;
            end
        end
    endtask

    // watchdog on the falling edge, away from the checks
    always @(negedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, writebacks missing: saw %0d of %0d",
                     cycleCount, wbSeen, expNum.size());
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] lfsr;
        bit          stallOn;
        int          drained;
        int          i;
        lfsr      = 32'ha67d8a3e;
        drained   = 0;
        rstN      = 1'b0;
        instStall = 1'b0;
        dataStall = 1'b0;
        for (i = 0; i < IMEM_WORDS; i++) begin
            progMem[i] = 32'h0;
        end
        for (i = 0; i < DMEM_WORDS; i++) begin
            dataMem[i] = fillWord(i);
        end
        loadProgram();
        cycleLimit = RESET_CYCLES + 4 * progLen + 50;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        do begin
            // random stalls over the second half of the writebacks
            stallOn = (wbSeen >= expNum.size() / 2) && (wbSeen < expNum.size());
            if (stallOn) begin
                lfsr      = stepLfsr(lfsr);
                instStall = lfsr[0];
                lfsr      = stepLfsr(lfsr);
                dataStall = lfsr[0];
            end else begin
                instStall = 1'b0;
                dataStall = 1'b0;
            end
            @(posedge clk);
            checkFetch();
            checkWriteback();
            commitStore();
            cyclesOut++;
            if (wbSeen == expNum.size()) begin
                drained++;
            end
            if (drained < DRAIN_CYCLES) begin
                @(negedge clk);
            end
        end while (drained < DRAIN_CYCLES);
        reportTest("drain");

        for (i = 0; i < memIdx.size(); i++) begin
            curChecks++;
            assert (dataMem[memIdx[i]] === memVal[i]) else begin
                $display("ERR %0t: data word %0d holds %h, expected %h", $time, memIdx[i],
                         dataMem[memIdx[i]], memVal[i]);
                countError();
            end
        end
        reportTest("memory");

        $display("summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed,
                 totalErrors);
        if (totalErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
